// File: source/rx_pkg.sv
package rx_pkg;

    // --------------------
    // vector types
    // --------------------

    // one signed I or Q component
    typedef logic signed [15:0] iq_t;

    // complex sample, Q upper half, I lower half
    typedef logic [31:0] sample_t;

    // apb data word and byte address
    typedef logic [31:0] reg_data_t;
    typedef logic [7:0]  reg_addr_t;

    // --------------------
    // register offsets
    // --------------------

    localparam reg_addr_t REG_CTRL         = 8'h00;
    localparam reg_addr_t REG_CFO_ADJ      = 8'h04;
    localparam reg_addr_t REG_SAMPLE_COUNT = 8'h08;
    localparam reg_addr_t REG_LAST_SAMPLE  = 8'h0C;

    // --------------------
    // arithmetic constants
    // --------------------

    // peak value of the sine table
    localparam logic [15:0] SINE_AMP = 16'd32767;

    // quarter-wave index bits, 64 phase steps per turn
    localparam int LUT_IDX_W = 4;

    // product scaling back to 16 bits
    localparam int MULT_SHIFT = 15;

endpackage

// File: source/cfo_nco.sv
`timescale 1ns/1ps

module cfo_nco #(
    parameter int PHASE_W = 20
) (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic                 manual_mode_i,
    input  logic                 cfo_adj_valid_i,
    input  logic [PHASE_W-1:0]   cfo_adj_i,
    input  logic                 sample_valid_i,
    output logic [PHASE_W-1:0]   freq_word_o,
    output rx_pkg::sample_t      rot_o,
    output logic                 rot_valid_o
);

    import rx_pkg::*;

    // quadrant plus quarter-wave index
    localparam int ADDR_W = LUT_IDX_W + 2;

    logic [PHASE_W-1:0] freq_word;
    logic [PHASE_W-1:0] phase;
    logic [ADDR_W-1:0]  sin_addr;
    logic [ADDR_W-1:0]  cos_addr;
    iq_t                sin_val;
    iq_t                cos_val;

    // round(32767 * sin(2*pi*k/64)), k = 0..15
    function automatic iq_t quarter_sin(input logic [LUT_IDX_W-1:0] k);
        iq_t val;
        case (k)
            4'd1:    val = 16'sd3212;
            4'd2:    val = 16'sd6393;
            4'd3:    val = 16'sd9512;
            4'd4:    val = 16'sd12539;
            4'd5:    val = 16'sd15446;
            4'd6:    val = 16'sd18204;
            4'd7:    val = 16'sd20787;
            4'd8:    val = 16'sd23170;
            4'd9:    val = 16'sd25329;
            4'd10:   val = 16'sd27245;
            4'd11:   val = 16'sd28898;
            4'd12:   val = 16'sd30273;
            4'd13:   val = 16'sd31356;
            4'd14:   val = 16'sd32137;
            4'd15:   val = 16'sd32609;
            default: val = 16'sd0;
        endcase
        return val;
    endfunction

    // full-wave sine from the quarter table by symmetry
    function automatic iq_t wave_lookup(input logic [ADDR_W-1:0] n);
        logic [LUT_IDX_W-1:0] idx;
        logic [LUT_IDX_W-1:0] mirror;
        iq_t                  mag;
        idx    = n[LUT_IDX_W-1:0];
        mirror = ~idx + 1'b1;
        if (!n[LUT_IDX_W]) begin
            mag = quarter_sin(idx);
        end else if (idx == '0) begin
            mag = iq_t'(SINE_AMP);
        end else begin
            mag = quarter_sin(mirror);
        end
        return n[ADDR_W-1] ? -mag : mag;
    endfunction

    // --------------------
    // frequency word and phase
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            freq_word <= '0;
            phase     <= '0;
        end else if (manual_mode_i) begin
            freq_word <= '0;
            phase     <= '0;
        end else begin
            // adjustments are relative to the current word
            if (cfo_adj_valid_i) begin
                freq_word <= freq_word - cfo_adj_i;
            end
            if (sample_valid_i) begin
                phase <= phase + freq_word;
            end
        end
    end

    // --------------------
    // rotator
    // --------------------

    assign sin_addr = phase[PHASE_W-1 -: ADDR_W];
    assign cos_addr = sin_addr + ADDR_W'(1 << LUT_IDX_W);
    assign sin_val  = wave_lookup(sin_addr);
    assign cos_val  = wave_lookup(cos_addr);

    // phase before this sample's advance
    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            rot_o <= {sin_val, cos_val};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rot_valid_o <= 1'b0;
        end else begin
            rot_valid_o <= sample_valid_i;
        end
    end

    assign freq_word_o = freq_word;

endmodule

// File: source/cplx_mult.sv
`timescale 1ns/1ps

module cplx_mult (
    input  logic            clk_i,
    input  logic            reset_ni,
    input  rx_pkg::sample_t a_i,
    input  rx_pkg::sample_t b_i,
    input  logic            valid_i,
    output rx_pkg::sample_t p_o,
    output logic            valid_o
);

    import rx_pkg::*;

    iq_t                a_re;
    iq_t                a_im;
    iq_t                b_re;
    iq_t                b_im;
    logic signed [31:0] prod_rr;
    logic signed [31:0] prod_ii;
    logic signed [31:0] prod_ri;
    logic signed [31:0] prod_ir;
    logic               valid_q;
    logic signed [32:0] sum_i;
    logic signed [32:0] sum_q;

    // round half up, shift and clip to 16 bits
    function automatic iq_t round_sat(input logic signed [32:0] x);
        logic signed [32:0] rounded;
        logic signed [32:0] shifted;
        rounded = x + (33'sd1 <<< (MULT_SHIFT - 1));
        shifted = rounded >>> MULT_SHIFT;
        if (shifted > 33'sd32767) begin
            return 16'sh7fff;
        end else if (shifted < -33'sd32768) begin
            return 16'sh8000;
        end
        return iq_t'(shifted[15:0]);
    endfunction

    assign a_re = iq_t'(a_i[15:0]);
    assign a_im = iq_t'(a_i[31:16]);
    assign b_re = iq_t'(b_i[15:0]);
    assign b_im = iq_t'(b_i[31:16]);

    // --------------------
    // stage 1, products
    // --------------------

    always_ff @(posedge clk_i) begin
        prod_rr <= a_re * b_re;
        prod_ii <= a_im * b_im;
        prod_ri <= a_re * b_im;
        prod_ir <= a_im * b_re;
    end

    // --------------------
    // stage 2, sum and scale
    // --------------------

    assign sum_i = prod_rr - prod_ii;
    assign sum_q = prod_ri + prod_ir;

    always_ff @(posedge clk_i) begin
        p_o <= {round_sat(sum_q), round_sat(sum_i)};
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            valid_q <= valid_i;
            valid_o <= valid_q;
        end
    end

endmodule

// File: source/rx_regmap.sv
`timescale 1ns/1ps

module rx_regmap #(
    parameter int PHASE_W = 20
) (
    input  logic              clk_i,
    input  logic              reset_ni,

    // apb slave
    input  rx_pkg::reg_addr_t paddr_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  rx_pkg::reg_data_t pwdata_i,
    output rx_pkg::reg_data_t prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,

    // sample monitor
    input  rx_pkg::sample_t   sample_i,
    input  logic              sample_valid_i,

    // nco control
    input  logic [PHASE_W-1:0] freq_word_i,
    output logic              manual_mode_o,
    output logic              cfo_adj_valid_o,
    output logic [PHASE_W-1:0] cfo_adj_o
);

    import rx_pkg::*;

    logic      access;
    logic      wr_en;
    logic      addr_hit;
    reg_data_t rdata;
    logic      manual_mode;
    reg_data_t sample_count;
    sample_t   last_sample;

    // --------------------
    // apb decode
    // --------------------

    // no wait states, every access cycle completes
    assign access   = psel_i && penable_i;
    assign wr_en    = access && pwrite_i;
    assign pready_o = access;

    always_comb begin
        addr_hit = 1'b1;
        rdata    = '0;
        case (paddr_i)
            REG_CTRL: begin
                rdata = reg_data_t'(manual_mode);
            end
            REG_CFO_ADJ: begin
                rdata = reg_data_t'(signed'(freq_word_i));
            end
            REG_SAMPLE_COUNT: begin
                rdata = sample_count;
            end
            REG_LAST_SAMPLE: begin
                rdata = last_sample;
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    assign prdata_o  = (access && !pwrite_i) ? rdata : '0;
    assign pslverr_o = access && !addr_hit;

    // --------------------
    // control
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            manual_mode <= 1'b0;
        end else if (wr_en && paddr_i == REG_CTRL) begin
            manual_mode <= pwdata_i[0];
        end
    end

    assign manual_mode_o = manual_mode;

    // relative adjustment, applied by the nco at the end of the access
    assign cfo_adj_valid_o = wr_en && (paddr_i == REG_CFO_ADJ);
    assign cfo_adj_o       = pwdata_i[PHASE_W-1:0];

    // --------------------
    // status
    // --------------------

    // wraps at 2^32
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_count <= '0;
        end else if (sample_valid_i) begin
            sample_count <= sample_count + 32'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            last_sample <= sample_i;
        end
    end

endmodule

// File: source/rx_top.sv
`timescale 1ns/1ps

module rx_top #(
    parameter int PHASE_W = 20
) (
    input  logic              clk_i,
    input  logic              reset_ni,

    // apb slave
    input  rx_pkg::reg_addr_t paddr_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  rx_pkg::reg_data_t pwdata_i,
    output rx_pkg::reg_data_t prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,

    // input stream
    input  rx_pkg::sample_t   sample_i,
    input  logic              sample_valid_i,

    // derotated stream
    output rx_pkg::sample_t   sample_o,
    output logic              sample_valid_o
);

    import rx_pkg::*;

    logic               manual_mode;
    logic               cfo_adj_valid;
    logic [PHASE_W-1:0] cfo_adj;
    logic [PHASE_W-1:0] freq_word;
    sample_t            rot;
    logic               rot_valid;
    sample_t            sample_d;

    rx_regmap #(
        .PHASE_W(PHASE_W)
    ) rx_regmap_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .paddr_i(paddr_i),
        .psel_i(psel_i),
        .penable_i(penable_i),
        .pwrite_i(pwrite_i),
        .pwdata_i(pwdata_i),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .sample_i(sample_i),
        .sample_valid_i(sample_valid_i),
        .freq_word_i(freq_word),
        .manual_mode_o(manual_mode),
        .cfo_adj_valid_o(cfo_adj_valid),
        .cfo_adj_o(cfo_adj)
    );

    cfo_nco #(
        .PHASE_W(PHASE_W)
    ) cfo_nco_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .manual_mode_i(manual_mode),
        .cfo_adj_valid_i(cfo_adj_valid),
        .cfo_adj_i(cfo_adj),
        .sample_valid_i(sample_valid_i),
        .freq_word_o(freq_word),
        .rot_o(rot),
        .rot_valid_o(rot_valid)
    );

    // align sample with the registered rotator
    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            sample_d <= sample_i;
        end
    end

    cplx_mult cplx_mult_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .a_i(sample_d),
        .b_i(rot),
        .valid_i(rot_valid),
        .p_o(sample_o),
        .valid_o(sample_valid_o)
    );

endmodule

// File: sim/rx_tb.sv
`timescale 1ns/1ps

module rx_tb;

    import rx_pkg::*;

    localparam int  PHASE_W   = 20;
    localparam int  N_ZERO    = 200;
    localparam int  N_CFO     = 300;
    localparam int  N_FULL    = 100;
    localparam int  N_MANUAL  = 100;
    localparam int  N_TAIL    = 20;
    localparam int  N_ADJ     = 8;
    localparam int  MAX_GAP   = 3;
    localparam int  DRAIN_MAX = 20;
    localparam real PI        = 3.14159265358979;

    // worst case run length plus a margin
    localparam int N_SAMPLES      = N_ZERO + N_CFO + N_FULL + N_MANUAL + N_TAIL;
    localparam int N_APB          = N_ADJ + 16;
    localparam int TIMEOUT_CYCLES = N_SAMPLES * (MAX_GAP + 1) + N_APB * 4
                                    + 6 * DRAIN_MAX + 200;

    logic      clk_i;
    logic      reset_ni;
    reg_addr_t paddr_i;
    logic      psel_i;
    logic      penable_i;
    logic      pwrite_i;
    reg_data_t pwdata_i;
    reg_data_t prdata_o;
    logic      pready_o;
    logic      pslverr_o;
    sample_t   sample_i;
    logic      sample_valid_i;
    sample_t   sample_o;
    logic      sample_valid_o;

    int cycle         = 0;
    int error_count   = 0;
    int check_count   = 0;
    int test_num      = 0;
    int errs_at_start = 0;

    // reference model state
    int                 quarter_tab[16];
    logic [PHASE_W-1:0] m_freq;
    logic [PHASE_W-1:0] m_phase;
    logic [PHASE_W-1:0] next_freq;
    logic [PHASE_W-1:0] next_phase;
    logic               m_manual;
    reg_data_t          m_count;
    sample_t            m_last;
    sample_t            exp_data[$];
    int                 exp_accept[$];

    rx_top #(
        .PHASE_W(PHASE_W)
    ) i_dut (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .paddr_i(paddr_i),
        .psel_i(psel_i),
        .penable_i(penable_i),
        .pwrite_i(pwrite_i),
        .pwdata_i(pwdata_i),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .sample_i(sample_i),
        .sample_valid_i(sample_valid_i),
        .sample_o(sample_o),
        .sample_valid_o(sample_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    // --------------------
    // checks and helpers
    // --------------------

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        $display("test %0d %-14s %s, %0d errors", test_num, name,
                 (error_count == errs_at_start) ? "ok" : "failed",
                 error_count - errs_at_start);
        errs_at_start = error_count;
    endtask

    // sine at step n of 64 per turn
    function automatic int full_sin(input int n);
        int m;
        m = n % 64;
        if (m >= 32) begin
            return -full_sin(m - 32);
        end
        if (m > 16) begin
            m = 32 - m;
        end
        if (m == 16) begin
            return int'(SINE_AMP);
        end
        return quarter_tab[m];
    endfunction

    function automatic logic [15:0] scale_sat(input longint x);
        longint r;
        r = (x + 64'sd16384) >>> MULT_SHIFT;
        if (r > 32767) begin
            r = 32767;
        end else if (r < -32768) begin
            r = -32768;
        end
        return r[15:0];
    endfunction

    function automatic sample_t rotate(input sample_t s, input int step);
        longint ar;
        longint ai;
        longint c;
        longint sn;
        ar = longint'($signed(s[15:0]));
        ai = longint'($signed(s[31:16]));
        c  = full_sin(step + 16);
        sn = full_sin(step);
        return {scale_sat(ar * sn + ai * c), scale_sat(ar * c - ai * sn)};
    endfunction

    function automatic reg_data_t sign_extend(input logic [PHASE_W-1:0] w);
        return {{(32 - PHASE_W){w[PHASE_W-1]}}, w};
    endfunction

    // --------------------
    // reference model and monitor
    // --------------------

    always @(posedge clk_i) begin
        if (!reset_ni) begin
            m_freq   = '0;
            m_phase  = '0;
            m_manual = 1'b0;
            m_count  = '0;
        end else begin
            if (sample_valid_i) begin
                exp_data.push_back(rotate(sample_i,
                                          int'(m_phase[PHASE_W-1 -: LUT_IDX_W + 2])));
                exp_accept.push_back(cycle);
                m_count = m_count + 1;
                m_last  = sample_i;
            end
            next_freq  = m_freq;
            next_phase = m_phase;
            if (m_manual) begin
                next_freq  = '0;
                next_phase = '0;
            end else begin
                if (psel_i && penable_i && pwrite_i && paddr_i == REG_CFO_ADJ) begin
                    next_freq = m_freq - pwdata_i[PHASE_W-1:0];
                end
                if (sample_valid_i) begin
                    next_phase = m_phase + m_freq;
                end
            end
            if (psel_i && penable_i && pwrite_i && paddr_i == REG_CTRL) begin
                m_manual = pwdata_i[0];
            end
            m_freq  = next_freq;
            m_phase = next_phase;
        end
    end

    always @(negedge clk_i) begin
        if (reset_ni) begin
            if (sample_valid_o) begin
                if (exp_data.size() == 0) begin
                    error_count++;
                    $display("sample_valid_o high at cycle %0d with no sample in flight",
                             cycle);
                end else begin
                    check_equal("sample_o", sample_o, exp_data.pop_front());
                    check_equal("sample_o latency", cycle - exp_accept.pop_front(), 3);
                end
            end else if (exp_accept.size() != 0 && exp_accept[0] + 3 <= cycle) begin
                error_count++;
                $display("sample accepted at cycle %0d never came out", exp_accept[0]);
                void'(exp_data.pop_front());
                void'(exp_accept.pop_front());
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------

    task automatic apb_access(input logic write, input reg_addr_t addr,
                              input reg_data_t wdata, output reg_data_t rdata,
                              output logic slverr);
        @(posedge clk_i);
        paddr_i   <= addr;
        pwrite_i  <= write;
        pwdata_i  <= wdata;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        // setup cycle
        @(negedge clk_i);
        check_equal("pready_o", pready_o, 0);
        @(posedge clk_i);
        penable_i <= 1'b1;
        // no wait states in the access cycle
        @(negedge clk_i);
        check_equal("pready_o", pready_o, 1);
        rdata  = prdata_o;
        slverr = pslverr_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_data_t rdata;
        logic      slverr;
        apb_access(1'b1, addr, data, rdata, slverr);
        check_equal("pslverr_o", slverr, 0);
    endtask

    task automatic reg_read(input reg_addr_t addr, input string name,
                            input reg_data_t exp);
        reg_data_t rdata;
        logic      slverr;
        apb_access(1'b0, addr, '0, rdata, slverr);
        check_equal(name, rdata, exp);
        check_equal("pslverr_o", slverr, 0);
    endtask

    function automatic logic [15:0] full_scale_part();
        return ($urandom_range(1, 0) == 1) ? 16'h7fff : 16'h8000;
    endfunction

    task automatic send_samples(input int n, input bit full_scale);
        int      i;
        int      gap;
        sample_t s;
        for (i = 0; i < n; i++) begin
            gap = $urandom_range(MAX_GAP, 0);
            repeat (gap) begin
                @(posedge clk_i);
                sample_valid_i <= 1'b0;
                sample_i       <= $urandom;
            end
            s = full_scale ? {full_scale_part(), full_scale_part()} : sample_t'($urandom);
            @(posedge clk_i);
            sample_valid_i <= 1'b1;
            sample_i       <= s;
        end
        @(posedge clk_i);
        sample_valid_i <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_data.size() != 0 || sample_valid_i) && waited < DRAIN_MAX) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_data.size() != 0) begin
            error_count++;
            $display("%0d samples still in flight after %0d cycles",
                     exp_data.size(), DRAIN_MAX);
        end
    endtask

    initial begin
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
        end
        $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [PHASE_W-1:0] adj_sum;
        reg_data_t          wdata;
        reg_data_t          rdata;
        logic               slverr;
        int                 k;

        reset_ni       = 1'b0;
        paddr_i        = '0;
        psel_i         = 1'b0;
        penable_i      = 1'b0;
        pwrite_i       = 1'b0;
        pwdata_i       = '0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        void'($urandom(32'h325f27e7));
        for (k = 0; k < 16; k++) begin
            quarter_tab[k] = int'(32767.0 * $sin(2.0 * PI * k / 64.0));
        end

        repeat (4) @(posedge clk_i);
        reset_ni <= 1'b1;

        @(negedge clk_i);
        check_equal("sample_valid_o", sample_valid_o, 0);
        reg_read(REG_CFO_ADJ, "CFO_ADJ", 32'h0);
        reg_read(REG_SAMPLE_COUNT, "SAMPLE_COUNT", 32'h0);
        report_test("reset");

        send_samples(N_ZERO, 1'b0);
        wait_drain();
        report_test("zero_cfo");

        // frequency word moves by relative adjustments only
        adj_sum = '0;
        for (k = 0; k < N_ADJ; k++) begin
            wdata   = $urandom;
            adj_sum = adj_sum + wdata[PHASE_W-1:0];
            reg_write(REG_CFO_ADJ, wdata);
        end
        reg_read(REG_CFO_ADJ, "CFO_ADJ", sign_extend('0 - adj_sum));
        send_samples(N_CFO, 1'b0);
        wait_drain();
        report_test("cfo_rotation");

        send_samples(N_FULL, 1'b1);
        wait_drain();
        report_test("saturation");

        reg_write(REG_CTRL, 32'h1);
        reg_read(REG_CTRL, "CTRL", 32'h1);
        reg_read(REG_CFO_ADJ, "CFO_ADJ", 32'h0);
        send_samples(N_MANUAL, 1'b0);
        wait_drain();
        reg_write(REG_CTRL, 32'h0);
        report_test("manual_mode");

        send_samples(N_TAIL, 1'b0);
        wait_drain();
        reg_read(REG_SAMPLE_COUNT, "SAMPLE_COUNT", m_count);
        reg_read(REG_LAST_SAMPLE, "LAST_SAMPLE", m_last);
        apb_access(1'b0, 8'h10, '0, rdata, slverr);
        check_equal("pslverr_o", slverr, 1);
        check_equal("prdata_o", rdata, 32'h0);
        apb_access(1'b1, 8'h10, $urandom, rdata, slverr);
        check_equal("pslverr_o", slverr, 1);
        report_test("status_regs");

        $display("%0d tests, %0d checks, %0d errors", test_num, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
source/rx_pkg.sv
source/cfo_nco.sv
source/cplx_mult.sv
source/rx_regmap.sv
source/rx_top.sv
sim/rx_tb.sv

// File: Bender.yml
package:
  name: rx_cfo

sources:
  - source/rx_pkg.sv
  - source/cfo_nco.sv
  - source/cplx_mult.sv
  - source/rx_regmap.sv
  - source/rx_top.sv
  - target: simulation
    files:
      - sim/rx_tb.sv
